// ==== logic/safe_domain_params.svh ====
// pad count, pad select codes, slow clock divide ratio, reset hold length
`ifndef SAFE_DOMAIN_PARAMS_SVH
`define SAFE_DOMAIN_PARAMS_SVH

// ******************************
// pads
// ******************************

// number of io pads
// each peripheral group is exactly this wide, pad k carries group bit k
`define N_IO 8

// width of one pad select field
`define PAD_SEL_W 2

// pad select codes, one per pad
`define PAD_SEL_PERIO  2'd0
`define PAD_SEL_APBIO  2'd1
`define PAD_SEL_FPGAIO 2'd2
// pad fully released, no output and no input routing
`define PAD_SEL_OFF    2'd3

// ******************************
// clocking
// ******************************

// ref_clk_i cycles per slow tick
// slow_clk_o phases are each this many ref cycles long
`define SLOW_DIV 4

// ******************************
// reset
// ******************************

// slow ticks that rst_no stays low after rst_n_i is released
`define RST_HOLD_TICKS 3

`endif

// ==== logic/safe_domain_pkg.sv ====
// width typedefs, pad bus struct and reset sequencer state enum
`default_nettype none

`include "safe_domain_params.svh"

package safe_domain_pkg;

  // ******************************
  // pad types
  // ******************************

  // select code of a single pad
  typedef logic [`PAD_SEL_W-1:0] pad_sel_t;

  // one bit per pad, or per group signal
  typedef logic [`N_IO-1:0] pad_vec_t;

  // per-pad select, index k is pad k
  typedef pad_sel_t [`N_IO-1:0] pad_mux_t;

  // output and output enable of a group
  // same layout on the pad side
  typedef struct packed {
    pad_vec_t out;
    pad_vec_t oe;
  } pad_bus_t;

  // ******************************
  // counter types
  // ******************************

  // slow clock divider count, 0 .. SLOW_DIV-1
  typedef logic [$clog2(`SLOW_DIV + 1)-1:0] div_cnt_t;

  // slow tick count while holding reset
  typedef logic [$clog2(`RST_HOLD_TICKS + 1)-1:0] hold_cnt_t;

  // ******************************
  // reset sequencer states
  // ******************************

  // wait: external reset asserted
  // hold: counting slow ticks
  // run:  reset released, pads enabled
  typedef enum logic [1:0] {
    RST_WAIT,
    RST_HOLD,
    RST_RUN
  } rst_state_e;

endpackage

`default_nettype wire

// ==== logic/slow_clk_gen.sv ====
// ref clock divider with slow clock level and one-cycle slow tick
`default_nettype none

`include "safe_domain_params.svh"

module slow_clk_gen (
  input  logic ref_clk_i,
  input  logic rst_n_i,
  // one ref cycle high every SLOW_DIV cycles
  output logic slow_tick_o,
  // divided clock level that is low out of reset
  output logic slow_clk_o
);

  // divider count
  safe_domain_pkg::div_cnt_t cnt_q;
  safe_domain_pkg::div_cnt_t cnt_d;

  // last count of a divide period
  logic wrap;

  logic tick_q;
  logic slow_clk_q;

  // ******************************
  // divide counter
  // ******************************

  assign wrap = (cnt_q == safe_domain_pkg::div_cnt_t'(`SLOW_DIV - 1));

  // wraps back to zero after SLOW_DIV-1
  always_comb begin
    if (wrap) begin
      cnt_d = '0;
    end else begin
      cnt_d = cnt_q + 1'b1;
    end
  end

  always_ff @(posedge ref_clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // ******************************
  // tick and slow clock
  // ******************************

  // tick registered off the wrap for a glitch free output
  // slow clock flips on the same edge as the tick rises
  always_ff @(posedge ref_clk_i) begin
    if (!rst_n_i) begin
      tick_q     <= 1'b0;
      slow_clk_q <= 1'b0;
    end else begin
      tick_q <= wrap;
      if (wrap) begin
        slow_clk_q <= ~slow_clk_q;
      end
    end
  end

  assign slow_tick_o = tick_q;
  assign slow_clk_o  = slow_clk_q;

endmodule

`default_nettype wire

// ==== logic/reset_sequencer.sv ====
// FSM holding conditioned reset and pad enable low for a number of slow ticks
`default_nettype none

`include "safe_domain_params.svh"

module reset_sequencer (
  input  logic ref_clk_i,
  input  logic rst_n_i,
  // one-cycle tick from the slow clock divider
  input  logic slow_tick_i,
  // active low conditioned reset
  output logic rst_no,
  // pad output enables allowed
  output logic pads_en_o
);

  safe_domain_pkg::rst_state_e state_q;
  safe_domain_pkg::rst_state_e state_d;

  // slow ticks seen in hold
  safe_domain_pkg::hold_cnt_t hold_cnt_q;
  safe_domain_pkg::hold_cnt_t hold_cnt_d;

  // last hold tick reached
  logic hold_done;

  // registered run flag that drives both outputs
  logic run_q;

  assign hold_done =
    (hold_cnt_q == safe_domain_pkg::hold_cnt_t'(`RST_HOLD_TICKS - 1));

  // ******************************
  // next state
  // ******************************

  always_comb begin
    state_d    = state_q;
    hold_cnt_d = hold_cnt_q;
    case (state_q)
      // first cycle out of reset starts counting from zero
      safe_domain_pkg::RST_WAIT: begin
        state_d    = safe_domain_pkg::RST_HOLD;
        hold_cnt_d = '0;
      end
      // count slow ticks until the hold length is reached
      safe_domain_pkg::RST_HOLD: begin
        if (slow_tick_i) begin
          if (hold_done) begin
            state_d = safe_domain_pkg::RST_RUN;
          end else begin
            hold_cnt_d = hold_cnt_q + 1'b1;
          end
        end
      end
      // stays here until rst_n_i falls
      safe_domain_pkg::RST_RUN: begin
        state_d = safe_domain_pkg::RST_RUN;
      end
      default: begin
        state_d = safe_domain_pkg::RST_WAIT;
      end
    endcase
  end

  // ******************************
  // state and output registers
  // ******************************

  // run flag taken from the next state
  // so outputs rise in the same cycle the FSM enters run
  always_ff @(posedge ref_clk_i) begin
    if (!rst_n_i) begin
      state_q    <= safe_domain_pkg::RST_WAIT;
      hold_cnt_q <= '0;
      run_q      <= 1'b0;
    end else begin
      state_q    <= state_d;
      hold_cnt_q <= hold_cnt_d;
      run_q      <= (state_d == safe_domain_pkg::RST_RUN);
    end
  end

  // reset release and pad enable move together
  assign rst_no    = run_q;
  assign pads_en_o = run_q;

endmodule

`default_nettype wire

// ==== logic/pad_control.sv ====
// per-pad mux of outputs, enables and inputs between peripheral groups
`default_nettype none

`include "safe_domain_params.svh"

module pad_control (
  // select per pad
  input  safe_domain_pkg::pad_mux_t pad_mux_i,
  // gate for all pad output enables
  input  logic                      pads_en_i,

  // peripheral group outputs and enables
  input  safe_domain_pkg::pad_bus_t perio_i,
  input  safe_domain_pkg::pad_bus_t apbio_i,
  input  safe_domain_pkg::pad_bus_t fpgaio_i,

  // peripheral group inputs
  output safe_domain_pkg::pad_vec_t perio_in_o,
  output safe_domain_pkg::pad_vec_t apbio_in_o,
  output safe_domain_pkg::pad_vec_t fpgaio_in_o,

  // pad side
  input  safe_domain_pkg::pad_vec_t io_in_i,
  output safe_domain_pkg::pad_bus_t io_o
);

  // pad side outputs and enables before packing
  safe_domain_pkg::pad_vec_t pad_out;
  safe_domain_pkg::pad_vec_t pad_oe;

  // ******************************
  // per-pad routing
  // ******************************

  for (genvar k = 0; k < `N_IO; k++) begin : g_pad

    // select code of this pad
    safe_domain_pkg::pad_sel_t sel;

    // pad k output before enable gating
    logic out_k;
    logic oe_k;

    // input steering flags
    logic is_perio;
    logic is_apbio;
    logic is_fpgaio;

    assign sel = pad_mux_i[k];

    // pick bit k of the selected group
    // unused codes fall back to off
    always_comb begin
      case (sel)
        `PAD_SEL_PERIO: begin
          out_k = perio_i.out[k];
          oe_k  = perio_i.oe[k];
        end
        `PAD_SEL_APBIO: begin
          out_k = apbio_i.out[k];
          oe_k  = apbio_i.oe[k];
        end
        `PAD_SEL_FPGAIO: begin
          out_k = fpgaio_i.out[k];
          oe_k  = fpgaio_i.oe[k];
        end
        `PAD_SEL_OFF: begin
          out_k = 1'b0;
          oe_k  = 1'b0;
        end
        default: begin
          out_k = 1'b0;
          oe_k  = 1'b0;
        end
      endcase
    end

    assign pad_out[k] = out_k;
    // no pad drives until the conditioned reset is released
    assign pad_oe[k]  = oe_k & pads_en_i;

    // input path is not gated by pad enable
    assign is_perio  = (sel == `PAD_SEL_PERIO);
    assign is_apbio  = (sel == `PAD_SEL_APBIO);
    assign is_fpgaio = (sel == `PAD_SEL_FPGAIO);

    // only the selected group sees the pad
    // the other groups read zero
    assign perio_in_o[k]  = is_perio  & io_in_i[k];
    assign apbio_in_o[k]  = is_apbio  & io_in_i[k];
    assign fpgaio_in_o[k] = is_fpgaio & io_in_i[k];

  end

  // ******************************
  // pad bus
  // ******************************

  assign io_o.out = pad_out;
  assign io_o.oe  = pad_oe;

endmodule

`default_nettype wire

// ==== logic/safe_domain.sv ====
// always-on top with slow clock divider, reset sequencer and pad control
`default_nettype none

module safe_domain (
  input  logic                      ref_clk_i,
  input  logic                      rst_n_i,
  // conditioned system reset
  output logic                      rst_no,
  // divided reference clock
  output logic                      slow_clk_o,

  // ******************************
  // pads
  // ******************************

  input  safe_domain_pkg::pad_mux_t pad_mux_i,
  input  safe_domain_pkg::pad_vec_t io_in_i,
  output safe_domain_pkg::pad_vec_t io_out_o,
  output safe_domain_pkg::pad_vec_t io_oe_o,

  // ******************************
  // peripheral groups
  // ******************************

  input  safe_domain_pkg::pad_bus_t perio_i,
  input  safe_domain_pkg::pad_bus_t apbio_i,
  input  safe_domain_pkg::pad_bus_t fpgaio_i,
  output safe_domain_pkg::pad_vec_t perio_in_o,
  output safe_domain_pkg::pad_vec_t apbio_in_o,
  output safe_domain_pkg::pad_vec_t fpgaio_in_o
);

  // divider to sequencer
  logic slow_tick;
  // sequencer to pad control
  logic pads_en;
  // pad side outputs and enables
  safe_domain_pkg::pad_bus_t io_bus;

  // slow clock and tick
  slow_clk_gen i_slow_clk_gen (
    .ref_clk_i  (ref_clk_i),
    .rst_n_i    (rst_n_i),
    .slow_tick_o(slow_tick),
    .slow_clk_o (slow_clk_o)
  );

  // reset release after the hold window
  reset_sequencer i_reset_sequencer (
    .ref_clk_i  (ref_clk_i),
    .rst_n_i    (rst_n_i),
    .slow_tick_i(slow_tick),
    .rst_no     (rst_no),
    .pads_en_o  (pads_en)
  );

  // combinational pad mux
  pad_control i_pad_control (
    .pad_mux_i  (pad_mux_i),
    .pads_en_i  (pads_en),
    .perio_i    (perio_i),
    .apbio_i    (apbio_i),
    .fpgaio_i   (fpgaio_i),
    .perio_in_o (perio_in_o),
    .apbio_in_o (apbio_in_o),
    .fpgaio_in_o(fpgaio_in_o),
    .io_in_i    (io_in_i),
    .io_o       (io_bus)
  );

  // split pad bus onto the top ports
  assign io_out_o = io_bus.out;
  assign io_oe_o  = io_bus.oe;

endmodule

`default_nettype wire

// ==== tb/tb_safe_domain.sv ====
// testbench with clock, reset release window, slow clock phase and pad routing table checks
`default_nettype none

`include "safe_domain_params.svh"

module tb_safe_domain;

  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DLY   = 2;
  localparam int RST_CYCLES  = 2;
  localparam int NUM_FIXED   = 8;
  localparam int NUM_RAND    = 32;
  localparam int NUM_ENTRIES = NUM_FIXED + NUM_RAND;
  localparam int NUM_PHASES  = 6;
  localparam logic [31:0] SEED = 32'h4fcce64d;

  // release window in ref cycles after rst_n rises
  localparam int REL_MIN = `RST_HOLD_TICKS * `SLOW_DIV;
  localparam int REL_MAX = (`RST_HOLD_TICKS + 1) * `SLOW_DIV + 2;
  localparam int RESET_WINDOW = RST_CYCLES + REL_MAX;
  // two resets, one and a half table passes, slow clock check and margin
  localparam int TIMEOUT_CYCLES = 2 * RESET_WINDOW + NUM_ENTRIES + NUM_ENTRIES / 2
                                  + (NUM_PHASES + 2) * `SLOW_DIV + 64;

  // one table row
  typedef struct packed {
    safe_domain_pkg::pad_mux_t mux;
    safe_domain_pkg::pad_bus_t perio;
    safe_domain_pkg::pad_bus_t apbio;
    safe_domain_pkg::pad_bus_t fpgaio;
    safe_domain_pkg::pad_vec_t io_in;
  } stim_t;

  // expected pad side and group inputs
  typedef struct packed {
    safe_domain_pkg::pad_bus_t io;
    safe_domain_pkg::pad_vec_t perio_in;
    safe_domain_pkg::pad_vec_t apbio_in;
    safe_domain_pkg::pad_vec_t fpgaio_in;
  } resp_t;

  logic ref_clk = 1'b0;
  logic rst_n   = 1'b0;
  logic rst_no;
  logic slow_clk;
  safe_domain_pkg::pad_mux_t pad_mux;
  safe_domain_pkg::pad_vec_t io_in;
  safe_domain_pkg::pad_vec_t io_out;
  safe_domain_pkg::pad_vec_t io_oe;
  safe_domain_pkg::pad_bus_t perio;
  safe_domain_pkg::pad_bus_t apbio;
  safe_domain_pkg::pad_bus_t fpgaio;
  safe_domain_pkg::pad_vec_t perio_in;
  safe_domain_pkg::pad_vec_t apbio_in;
  safe_domain_pkg::pad_vec_t fpgaio_in;

  stim_t stim_tab [NUM_ENTRIES];
  // row currently on the DUT inputs
  stim_t cur_stim;
  int    error_count = 0;

  always #(CLK_PERIOD / 2) ref_clk = ~ref_clk;

  safe_domain dut0 (
    .ref_clk_i  (ref_clk),
    .rst_n_i    (rst_n),
    .rst_no     (rst_no),
    .slow_clk_o (slow_clk),
    .pad_mux_i  (pad_mux),
    .io_in_i    (io_in),
    .io_out_o   (io_out),
    .io_oe_o    (io_oe),
    .perio_i    (perio),
    .apbio_i    (apbio),
    .fpgaio_i   (fpgaio),
    .perio_in_o (perio_in),
    .apbio_in_o (apbio_in),
    .fpgaio_in_o(fpgaio_in)
  );

  // ******************************
  // failure and compare tasks
  // ******************************

  task automatic report_failure(input string reason);
    error_count++;
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_vec(input string name, input safe_domain_pkg::pad_vec_t exp_v,
                           input safe_domain_pkg::pad_vec_t act_v);
    if (act_v !== exp_v) begin
      report_failure($sformatf("FAILED %s expected 0x%h actual 0x%h", name, exp_v, act_v));
    end
  endtask

  task automatic check_bit(input string name, input logic exp_b, input logic act_b);
    if (act_b !== exp_b) begin
      report_failure($sformatf("FAILED %s expected 0x%h actual 0x%h", name, exp_b, act_b));
    end
  endtask

  // cycle counts such as a slow clock phase length
  task automatic check_len(input string name, input int exp_n, input int act_n);
    if (act_n != exp_n) begin
      report_failure($sformatf("FAILED %s expected 0x%h actual 0x%h", name, exp_n, act_n));
    end
  endtask

  // ******************************
  // table helpers and model
  // ******************************

  function automatic safe_domain_pkg::pad_mux_t uniform_mux(
    input safe_domain_pkg::pad_sel_t sel
  );
    safe_domain_pkg::pad_mux_t m;
    for (int k = 0; k < `N_IO; k++) begin
      m[k] = sel;
    end
    return m;
  endfunction

  // pad k gets code (k + offset) mod 4 and every code shows up
  function automatic safe_domain_pkg::pad_mux_t mixed_mux(input int offset);
    safe_domain_pkg::pad_mux_t m;
    for (int k = 0; k < `N_IO; k++) begin
      m[k] = safe_domain_pkg::pad_sel_t'((k + offset) % 4);
    end
    return m;
  endfunction

  function automatic safe_domain_pkg::pad_bus_t group_bus(input logic [31:0] out_v,
                                                          input logic [31:0] oe_v);
    safe_domain_pkg::pad_bus_t b;
    b.out = safe_domain_pkg::pad_vec_t'(out_v);
    b.oe  = safe_domain_pkg::pad_vec_t'(oe_v);
    return b;
  endfunction

  function automatic stim_t make_entry(input safe_domain_pkg::pad_mux_t mux,
                                       input safe_domain_pkg::pad_bus_t perio_b,
                                       input safe_domain_pkg::pad_bus_t apbio_b,
                                       input safe_domain_pkg::pad_bus_t fpgaio_b,
                                       input logic [31:0] pad_in);
    stim_t s;
    s.mux    = mux;
    s.perio  = perio_b;
    s.apbio  = apbio_b;
    s.fpgaio = fpgaio_b;
    s.io_in  = safe_domain_pkg::pad_vec_t'(pad_in);
    return s;
  endfunction

  // selection rule per pad
  // only the output enables depend on en
  function automatic resp_t expected_of(input stim_t s, input logic en);
    resp_t e;
    e = '0;
    for (int k = 0; k < `N_IO; k++) begin
      if (s.mux[k] == `PAD_SEL_PERIO) begin
        e.io.out[k]   = s.perio.out[k];
        e.io.oe[k]    = s.perio.oe[k] & en;
        e.perio_in[k] = s.io_in[k];
      end else if (s.mux[k] == `PAD_SEL_APBIO) begin
        e.io.out[k]   = s.apbio.out[k];
        e.io.oe[k]    = s.apbio.oe[k] & en;
        e.apbio_in[k] = s.io_in[k];
      end else if (s.mux[k] == `PAD_SEL_FPGAIO) begin
        e.io.out[k]    = s.fpgaio.out[k];
        e.io.oe[k]     = s.fpgaio.oe[k] & en;
        e.fpgaio_in[k] = s.io_in[k];
      end
    end
    return e;
  endfunction

  task automatic build_table();
    stim_tab[0] = make_entry(uniform_mux(`PAD_SEL_PERIO), group_bus('hA5, 'hFF),
                             group_bus('h5A, 'h0F), group_bus('h3C, 'hF0), 'h96);
    stim_tab[1] = make_entry(uniform_mux(`PAD_SEL_APBIO), group_bus('hA5, 'hFF),
                             group_bus('h5A, 'h0F), group_bus('h3C, 'hF0), 'h69);
    stim_tab[2] = make_entry(uniform_mux(`PAD_SEL_FPGAIO), group_bus('hA5, 'hFF),
                             group_bus('h5A, 'h0F), group_bus('h3C, 'hF0), 'hC3);
    // all pads off with groups fully driven
    stim_tab[3] = make_entry(uniform_mux(`PAD_SEL_OFF), group_bus('hFF, 'hFF),
                             group_bus('hFF, 'hFF), group_bus('hFF, 'hFF), 'hFF);
    stim_tab[4] = make_entry(mixed_mux(0), group_bus('h11, 'hEE),
                             group_bus('h22, 'hDD), group_bus('h44, 'hBB), 'h5A);
    stim_tab[5] = make_entry(mixed_mux(1), group_bus('hF0, 'h33),
                             group_bus('h0F, 'hCC), group_bus('hAA, 'h55), 'hA5);
    stim_tab[6] = make_entry(mixed_mux(2), group_bus('hFF, 'hFF),
                             group_bus('hFF, 'hFF), group_bus('hFF, 'hFF), 'hFF);
    // quiet groups with all pads high
    stim_tab[7] = make_entry(mixed_mux(3), group_bus('h00, 'h00),
                             group_bus('h00, 'h00), group_bus('h00, 'h00), 'hFF);
    for (int i = NUM_FIXED; i < NUM_ENTRIES; i++) begin
      stim_tab[i] = make_entry(safe_domain_pkg::pad_mux_t'($urandom()),
                               group_bus($urandom(), $urandom()),
                               group_bus($urandom(), $urandom()),
                               group_bus($urandom(), $urandom()), $urandom());
    end
  endtask

  // ******************************
  // drive and check tasks
  // ******************************

  task automatic drive_inputs(input stim_t s);
    cur_stim = s;
    pad_mux  = s.mux;
    perio    = s.perio;
    apbio    = s.apbio;
    fpgaio   = s.fpgaio;
    io_in    = s.io_in;
  endtask

  task automatic check_outputs(input logic en);
    resp_t exp_r;
    exp_r = expected_of(cur_stim, en);
    check_vec("io_out_o", exp_r.io.out, io_out);
    check_vec("io_oe_o", exp_r.io.oe, io_oe);
    check_vec("perio_in_o", exp_r.perio_in, perio_in);
    check_vec("apbio_in_o", exp_r.apbio_in, apbio_in);
    check_vec("fpgaio_in_o", exp_r.fpgaio_in, fpgaio_in);
  endtask

  // outputs checked in each reset cycle before release
  task automatic hold_in_reset();
    repeat (RST_CYCLES) begin
      @(posedge ref_clk);
      #DRIVE_DLY;
      check_bit("rst_no", 1'b0, rst_no);
      check_outputs(1'b0);
    end
    rst_n = 1'b1;
  endtask

  // counts rising edges until rst_no is seen high
  // table rows are driven through the hold window
  task automatic wait_for_release();
    int   cycles;
    logic released;
    cycles   = 0;
    released = 1'b0;
    while (!released) begin
      @(posedge ref_clk);
      cycles++;
      #DRIVE_DLY;
      drive_inputs(stim_tab[cycles % NUM_ENTRIES]);
      @(negedge ref_clk);
      released = (rst_no === 1'b1);
      if (!released) begin
        // no pad may drive in the hold window
        check_outputs(1'b0);
        if (cycles >= REL_MAX) begin
          report_failure($sformatf("rst_no still low %0d cycles after reset release", cycles));
        end
      end
    end
    if (cycles < REL_MIN) begin
      report_failure($sformatf("rst_no released after only %0d cycles", cycles));
    end
  endtask

  task automatic check_slow_clock();
    logic level;
    int   run_len;
    level   = slow_clk;
    run_len = 0;
    // align to a slow clock edge
    while (slow_clk === level) begin
      @(negedge ref_clk);
      run_len++;
      if (run_len > 2 * `SLOW_DIV) begin
        report_failure("slow_clk_o is not toggling");
      end
    end
    for (int p = 0; p < NUM_PHASES; p++) begin
      level   = slow_clk;
      run_len = 0;
      while (slow_clk === level) begin
        @(negedge ref_clk);
        run_len++;
        if (run_len > 2 * `SLOW_DIV) begin
          report_failure("slow_clk_o stuck at one level");
        end
      end
      check_len("slow_clk_o phase length", `SLOW_DIV, run_len);
    end
  endtask

  task automatic apply_and_check(input stim_t s);
    @(posedge ref_clk);
    #DRIVE_DLY;
    drive_inputs(s);
    @(negedge ref_clk);
    check_bit("rst_no", 1'b1, rst_no);
    check_outputs(1'b1);
  endtask

  // ******************************
  // main sequence and watchdog
  // ******************************

  initial begin
    stim_t drive_all;
    void'($urandom(SEED));
    build_table();
    // every pad on perio with oe set
    drive_all = make_entry(uniform_mux(`PAD_SEL_PERIO), group_bus('hFFFF_FFFF, 'hFFFF_FFFF),
                           group_bus('h0, 'h0), group_bus('h0, 'h0), 'hFFFF_FFFF);
    drive_inputs(drive_all);
    hold_in_reset();
    wait_for_release();
    check_slow_clock();
    for (int i = 0; i < NUM_ENTRIES / 2; i++) begin
      apply_and_check(stim_tab[i]);
    end
    // second reset in the middle of the run
    @(posedge ref_clk);
    #DRIVE_DLY;
    rst_n = 1'b0;
    drive_inputs(drive_all);
    hold_in_reset();
    wait_for_release();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      apply_and_check(stim_tab[i]);
    end
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    report_failure($sformatf("timeout, run did not end within %0d cycles", TIMEOUT_CYCLES));
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+logic
logic/safe_domain_pkg.sv
logic/slow_clk_gen.sv
logic/reset_sequencer.sv
logic/pad_control.sv
logic/safe_domain.sv
tb/tb_safe_domain.sv

// ==== Makefile ====
TOOL       := verilator
TOP        := tb_safe_domain
RTL_TOP    := safe_domain
FLIST      := flist.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
